/* verification/cache_tests.txt */
// op addr sel wdata expected, one access per line, all hex
// op: high digit 0 read, 1 write, 2 memory check, 3 reset, f end; low digit 0 hit, 1 refill, 2 write-back
01 00000104 f 00000000 3c3c0104
00 00000104 f 00000000 3c3c0104
10 00000104 5 11223344 00000000
00 00000104 f 00000000 3c220144
00 00000108 f 00000000 3c3c0108
02 00000204 f 00000000 3c3c0204
20 00000104 0 00000000 3c220144
20 00000108 0 00000000 3c3c0108
00 00000200 f 00000000 3c3c0200
11 0000034c c aabbccdd 00000000
00 0000034c f 00000000 aabb034c
00 00000340 f 00000000 3c3c0340
10 0000020c 2 0000ee00 00000000
00 0000020c f 00000000 3c3cee0c
30 00000000 0 00000000 00000000
01 0000034c f 00000000 3c3c034c
20 0000034c 0 00000000 3c3c034c
01 0000020c f 00000000 3c3c020c
20 0000020c 0 00000000 3c3c020c
ff 00000000 0 00000000 00000000

/* flist.f */
common/cache_pkg.sv
cache/beat_counter.sv
cache/tag_store.sv
cache/line_store.sv
cache/cache_ctrl.sv
rtl/cache_top.sv
verification/cache_asserts.sv
verification/cache_tb.sv

/* Bender.yml */
package:
  name: dm_cache

sources:
  - common/cache_pkg.sv
  - cache/beat_counter.sv
  - cache/tag_store.sv
  - cache/line_store.sv
  - cache/cache_ctrl.sv
  - rtl/cache_top.sv
  - target: test
    files:
      - verification/cache_asserts.sv
      - verification/cache_tb.sv

/* verification/cache_tb.sv */
`timescale 1ns/1ns

module cache_tb;

	localparam int mem_words   = 1024;
	localparam int max_tests   = 64;
	localparam int ack_timeout = 200;
	localparam logic [31:0] pattern_key = 32'h3c3c_0000;

	logic clk;
	logic reset;

	cache_pkg::wb_req_t cpu_req;
	cache_pkg::wb_rsp_t cpu_rsp;
	cache_pkg::wb_req_t mem_req;
	cache_pkg::wb_rsp_t mem_rsp;

	logic [31:0] mem [mem_words];
	logic [31:0] tests [max_tests*5];

	// Memory transfers seen during one processor access
	logic        log_we [$];
	logic [31:0] log_adr [$];
	logic [3:0]  log_sel [$];

	int   errors;
	int   checks;
	logic timed_out;

	cache_top UUT (
		.clk     (clk),
		.reset   (reset),
		.cpu_req (cpu_req),
		.cpu_rsp (cpu_rsp),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// Memory model
	//////////////////////////////////////////////////

	task automatic serve_transfer();
		int w;
		w = mem_req.adr[11:2];
		if (mem_req.adr[31:12] != '0) begin
			errors++;
			$display("Memory transfer outside the modeled range at address %h", mem_req.adr);
		end
		if (mem_req.we) begin
			for (int b = 0; b < 4; b++) begin
				if (mem_req.sel[b]) begin
					mem[w][b*8 +: 8] <= mem_req.dat[b*8 +: 8];
				end
			end
		end
		mem_rsp.dat <= mem[w];
		mem_rsp.ack <= 1'b1;
		log_we.push_back(mem_req.we);
		log_adr.push_back(mem_req.adr);
		log_sel.push_back(mem_req.sel);
	endtask

	initial begin : memory_model
		integer seed;
		logic   pending;
		int     delay_left;
		int     draw;
		seed    = 80780;
		pending = 1'b0;
		mem_rsp = '0;
		// Each word starts as its byte address XOR a key
		for (int i = 0; i < mem_words; i++) begin
			mem[i] = (i * 4) ^ pattern_key;
		end
		forever begin
			@(posedge clk);
			if (reset) begin
				mem_rsp <= '0;
				pending = 1'b0;
			end else begin
				mem_rsp.ack <= 1'b0;
				// Skip the edge where the cache is still taking our ack
				if (mem_req.cyc && mem_req.stb && !mem_rsp.ack) begin
					draw = pending ? delay_left : ($random(seed) & 3);
					pending = (draw != 0);
					delay_left = draw - 1;
					if (draw == 0) begin
						serve_transfer();
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Processor side
	//////////////////////////////////////////////////

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic run_access(input logic we, input logic [31:0] adr, input logic [3:0] sel,
			input logic [31:0] wdat, output logic [31:0] rdat, output int edges);
		logic ack_seen;
		ack_seen = 1'b0;
		edges    = 0;
		rdat     = '0;
		log_we.delete();
		log_adr.delete();
		log_sel.delete();
		@(posedge clk);
		cpu_req <= '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: wdat};
		while (!ack_seen && edges < ack_timeout) begin
			@(posedge clk);
			edges++;
			if (cpu_rsp.ack) begin
				ack_seen = 1'b1;
				rdat     = cpu_rsp.dat;
			end
		end
		cpu_req <= '0;
		if (!ack_seen) begin
			errors++;
			timed_out = 1'b1;
			$display("No processor ack within %0d cycles for address %h", ack_timeout, adr);
		end
	endtask

	// Kind 0 is a hit, 1 a clean refill, 2 a write-back and refill
	task automatic check_traffic(input logic [3:0] kind, input logic [31:0] adr);
		int n_wr;
		int n_all;
		int k;
		n_wr  = (kind == 4'h2) ? 4 : 0;
		n_all = (kind == 4'h0) ? 0 : n_wr + 4;
		compare("mem transfer count", log_we.size(), n_all);
		if (log_we.size() == n_all) begin
			for (int i = 0; i < n_all; i++) begin
				k = i % 4;
				compare("mem_req.we", log_we[i], i < n_wr);
				// Write-back tag belongs to the victim, so only index and word are known
				if (i < n_wr) begin
					compare("mem_req.sel", log_sel[i], 4'hf);
					compare("mem_req.adr[7:0]", log_adr[i][7:0], {adr[7:4], k[1:0], 2'b00});
				end else begin
					compare("mem_req.adr", log_adr[i], {adr[31:4], k[1:0], 2'b00});
				end
			end
		end
	endtask

	initial begin : stimulus
		logic [31:0] op, adr, sel, wdat, expd, rdat;
		int   edges;
		int   t;
		logic done;
		errors    = 0;
		checks    = 0;
		timed_out = 1'b0;
		cpu_req   = '0;
		reset     = 1'b1;
		$readmemh("verification/cache_tests.txt", tests);
		apply_reset();
		t    = 0;
		done = 1'b0;
		while (!done && !timed_out) begin
			op   = tests[t*5];
			adr  = tests[t*5+1];
			sel  = tests[t*5+2];
			wdat = tests[t*5+3];
			expd = tests[t*5+4];
			case (op[7:4])
				4'h0, 4'h1: begin
					run_access(op[4], adr, sel[3:0], wdat, rdat, edges);
					if (!timed_out) begin
						if (!op[4]) begin
							compare("cpu_rsp.dat", rdat, expd);
						end
						check_traffic(op[3:0], adr);
						if (op[3:0] == 4'h0) begin
							compare("hit latency", edges - 1, 2);
						end
					end
				end
				4'h2: compare("mem word", mem[adr[11:2]], expd);
				4'h3: apply_reset();
				4'hf: done = 1'b1;
				default: begin
					errors++;
					$display("Unknown operation in test entry %0d", t);
					done = 1'b1;
				end
			endcase
			t++;
			if (t == max_tests) begin
				done = 1'b1;
			end
		end
		errors = errors + UUT.u_asserts.failures;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* verification/cache_asserts.sv */
`timescale 1ns/1ns

module cache_asserts (
	input logic               clk,
	input logic               reset,
	input cache_pkg::wb_req_t cpu_req,
	input cache_pkg::wb_rsp_t cpu_rsp,
	input cache_pkg::wb_req_t mem_req,
	input cache_pkg::wb_rsp_t mem_rsp
);

	// Number of failed properties
	int failures = 0;

	// Strobe only inside a cycle
	cpu_stb_cyc: assert property (@(posedge clk) disable iff (reset) cpu_req.stb |-> cpu_req.cyc)
		else begin
			failures++;
			$error("processor stb without cyc");
		end
	mem_stb_cyc: assert property (@(posedge clk) disable iff (reset) mem_req.stb |-> mem_req.cyc)
		else begin
			failures++;
			$error("memory stb without cyc");
		end

	// Master holds the request until ack
	cpu_hold: assert property (@(posedge clk) disable iff (reset)
		(cpu_req.stb && !cpu_rsp.ack) |=> $stable(cpu_req))
		else begin
			failures++;
			$error("processor request changed before ack");
		end
	mem_hold: assert property (@(posedge clk) disable iff (reset)
		(mem_req.stb && !mem_rsp.ack) |=> $stable(mem_req))
		else begin
			failures++;
			$error("memory request changed before ack");
		end

	cpu_ack_pulse: assert property (@(posedge clk) disable iff (reset) cpu_rsp.ack |=> !cpu_rsp.ack)
		else begin
			failures++;
			$error("processor ack longer than one cycle");
		end

endmodule

bind cache_top cache_asserts u_asserts (.*);

/* rtl/cache_top.sv */
`timescale 1ns/1ns

module cache_top (
	input  logic               clk,
	input  logic               reset,
	input  cache_pkg::wb_req_t cpu_req,
	output cache_pkg::wb_rsp_t cpu_rsp,
	output cache_pkg::wb_req_t mem_req,
	input  cache_pkg::wb_rsp_t mem_rsp
);

	// Lookup results
	logic                        hit;
	logic                        victim_dirty;
	logic [cache_pkg::tag_w-1:0] victim_tag;

	// Line data
	logic [31:0] rd_word;
	logic [31:0] victim_word;

	// Beat sequencing
	logic [1:0] beat;
	logic       last_beat;
	logic       beat_clear;
	logic       beat_step;

	// Store enables
	logic       tag_install;
	logic       mark_dirty;
	logic       word_write;
	logic       refill_write;
	logic [1:0] sel_word;

	//////////////////////////////////////////////////
	// Controller
	//////////////////////////////////////////////////

	cache_ctrl u_ctrl (
		.clk          (clk),
		.reset        (reset),
		.cpu_req      (cpu_req),
		.cpu_rsp      (cpu_rsp),
		.mem_req      (mem_req),
		.mem_rsp      (mem_rsp),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.rd_word      (rd_word),
		.victim_word  (victim_word),
		.beat         (beat),
		.last_beat    (last_beat),
		.beat_clear   (beat_clear),
		.beat_step    (beat_step),
		.tag_install  (tag_install),
		.mark_dirty   (mark_dirty),
		.word_write   (word_write),
		.refill_write (refill_write),
		.sel_word     (sel_word)
	);

	beat_counter u_beat (
		.clk   (clk),
		.reset (reset),
		.clear (beat_clear),
		.step  (beat_step),
		.beat  (beat),
		.last  (last_beat)
	);

	//////////////////////////////////////////////////
	// Stores
	//////////////////////////////////////////////////

	// Processor address is held for the whole access
	tag_store u_tags (
		.clk          (clk),
		.reset        (reset),
		.addr         (cpu_req.adr),
		.install      (tag_install),
		.mark_dirty   (mark_dirty),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag)
	);

	line_store u_lines (
		.clk          (clk),
		.addr         (cpu_req.adr),
		.sel_word     (sel_word),
		.word_write   (word_write),
		.refill_write (refill_write),
		.sel          (cpu_req.sel),
		.wdata        (cpu_req.dat),
		.fill_data    (mem_rsp.dat),
		.rd_word      (rd_word),
		.victim_word  (victim_word)
	);

endmodule

/* cache/cache_ctrl.sv */
`timescale 1ns/1ns

module cache_ctrl (
	input  logic                        clk,
	input  logic                        reset,
	input  cache_pkg::wb_req_t          cpu_req,
	output cache_pkg::wb_rsp_t          cpu_rsp,
	output cache_pkg::wb_req_t          mem_req,
	input  cache_pkg::wb_rsp_t          mem_rsp,
	input  logic                        hit,
	input  logic                        victim_dirty,
	input  logic [cache_pkg::tag_w-1:0] victim_tag,
	input  logic [31:0]                 rd_word,
	input  logic [31:0]                 victim_word,
	input  logic [1:0]                  beat,
	input  logic                        last_beat,
	output logic                        beat_clear,
	output logic                        beat_step,
	output logic                        tag_install,
	output logic                        mark_dirty,
	output logic                        word_write,
	output logic                        refill_write,
	output logic [1:0]                  sel_word
);

	typedef enum logic [2:0] {
		s_idle,
		s_lookup,
		s_respond,
		s_write_back,
		s_refill,
		s_install
	} state_t;

	state_t state;
	state_t state_next;

	cache_pkg::cache_addr_u req_addr;

	//////////////////////////////////////////////////
	// State register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_idle;
		end else begin
			state <= state_next;
		end
	end

	// Request address, captured while the hit check runs
	always_ff @(posedge clk) begin
		if (state == s_lookup) begin
			req_addr <= cpu_req.adr;
		end
	end

	//////////////////////////////////////////////////
	// Next state and outputs
	//////////////////////////////////////////////////

	always_comb begin
		state_next   = state;
		cpu_rsp      = '0;
		mem_req      = '0;
		beat_clear   = 1'b0;
		beat_step    = 1'b0;
		tag_install  = 1'b0;
		mark_dirty   = 1'b0;
		word_write   = 1'b0;
		refill_write = 1'b0;
		sel_word     = req_addr.f.word;

		case (state)
			s_idle: begin
				if (cpu_req.cyc && cpu_req.stb) begin
					state_next = s_lookup;
				end
			end

			s_lookup: begin
				if (hit) begin
					state_next = s_respond;
				end else begin
					// Counter starts at word 0 for either memory phase
					beat_clear = 1'b1;
					state_next = victim_dirty ? s_write_back : s_refill;
				end
			end

			s_respond: begin
				cpu_rsp.ack = 1'b1;
				cpu_rsp.dat = rd_word;
				if (cpu_req.we) begin
					word_write = 1'b1;
					mark_dirty = 1'b1;
				end
				state_next = s_idle;
			end

			s_write_back: begin
				// Victim line goes out under its old tag
				mem_req.cyc = 1'b1;
				mem_req.stb = 1'b1;
				mem_req.we  = 1'b1;
				mem_req.sel = 4'hf;
				mem_req.adr = {victim_tag, req_addr.f.index, beat, 2'b00};
				mem_req.dat = victim_word;
				sel_word    = beat;
				if (mem_rsp.ack) begin
					beat_step = 1'b1;
					if (last_beat) begin
						beat_clear = 1'b1;
						state_next = s_refill;
					end
				end
			end

			s_refill: begin
				mem_req.cyc = 1'b1;
				mem_req.stb = 1'b1;
				mem_req.sel = 4'hf;
				mem_req.adr = {req_addr.f.tag, req_addr.f.index, beat, 2'b00};
				sel_word    = beat;
				if (mem_rsp.ack) begin
					refill_write = 1'b1;
					beat_step    = 1'b1;
					if (last_beat) begin
						state_next = s_install;
					end
				end
			end

			s_install: begin
				// Second lookup now hits the fresh line
				tag_install = 1'b1;
				state_next  = s_lookup;
			end

			default: begin
				state_next = s_idle;
			end
		endcase
	end

endmodule

/* cache/line_store.sv */
`timescale 1ns/1ns

module line_store (
	input  logic                   clk,
	input  cache_pkg::cache_addr_u addr,
	input  logic [1:0]             sel_word,
	input  logic                   word_write,
	input  logic                   refill_write,
	input  logic [3:0]             sel,
	input  logic [31:0]            wdata,
	input  logic [31:0]            fill_data,
	output logic [31:0]            rd_word,
	output logic [31:0]            victim_word
);

	cache_pkg::line_t lines [cache_pkg::num_lines];

	logic [cache_pkg::index_w-1:0] idx;
	logic [cache_pkg::word_w-1:0]  word;

	assign idx  = addr.f.index;
	assign word = addr.f.word;

	//////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////

	always_comb begin
		// Word addressed by the processor
		rd_word     = lines[idx][word];
		// Word of the current memory beat
		victim_word = lines[idx][sel_word];
	end

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////

	// Refill and processor writes never overlap in time
	always_ff @(posedge clk) begin
		if (refill_write) begin
			lines[idx][sel_word] <= fill_data;
		end else if (word_write) begin
			for (int b = 0; b < 4; b++) begin
				// Only enabled byte lanes change
				if (sel[b]) begin
					lines[idx][word][b*8 +: 8] <= wdata[b*8 +: 8];
				end
			end
		end
	end

endmodule

/* cache/tag_store.sv */
`timescale 1ns/1ns

module tag_store (
	input  logic                           clk,
	input  logic                           reset,
	input  cache_pkg::cache_addr_u         addr,
	input  logic                           install,
	input  logic                           mark_dirty,
	output logic                           hit,
	output logic                           victim_dirty,
	output logic [cache_pkg::tag_w-1:0]    victim_tag
);

	logic [cache_pkg::tag_w-1:0]     tags [cache_pkg::num_lines];
	logic [cache_pkg::num_lines-1:0] valid;
	logic [cache_pkg::num_lines-1:0] dirty;

	logic [cache_pkg::index_w-1:0] idx;

	assign idx = addr.f.index;

	//////////////////////////////////////////////////
	// Lookup
	//////////////////////////////////////////////////

	always_comb begin
		hit          = valid[idx] && (tags[idx] == addr.f.tag);
		// Resident line needs a write-back before replacement
		victim_dirty = valid[idx] && dirty[idx];
		victim_tag   = tags[idx];
	end

	//////////////////////////////////////////////////
	// Update
	//////////////////////////////////////////////////

	// Status bits
	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
			dirty <= '0;
		end else if (install) begin
			valid[idx] <= 1'b1;
			dirty[idx] <= 1'b0;
		end else if (mark_dirty) begin
			dirty[idx] <= 1'b1;
		end
	end

	// Tag array
	always_ff @(posedge clk) begin
		if (install) begin
			tags[idx] <= addr.f.tag;
		end
	end

endmodule

/* cache/beat_counter.sv */
`timescale 1ns/1ns

module beat_counter (
	input  logic       clk,
	input  logic       reset,
	input  logic       clear,
	input  logic       step,
	output logic [1:0] beat,
	output logic       last
);

	// Index of the final word in a line
	localparam logic [1:0] last_beat = 2'(cache_pkg::line_words - 1);

	//////////////////////////////////////////////////
	// Beat register
	//////////////////////////////////////////////////

	// Clear wins over step, so the controller can do both on the final ack
	always_ff @(posedge clk) begin
		if (reset) begin
			beat <= '0;
		end else if (clear) begin
			beat <= '0;
		end else if (step && !last) begin
			beat <= beat + 2'd1;
		end
	end

	// Holds on the last beat instead of wrapping
	always_comb begin
		last = (beat == last_beat);
	end

endmodule

/* common/cache_pkg.sv */
package cache_pkg;

	//////////////////////////////////////////////////
	// Cache geometry
	//////////////////////////////////////////////////

	// Words per line and number of lines
	localparam int line_words = 4;
	localparam int num_lines  = 16;

	// Address field widths
	localparam int index_w = 4;
	localparam int tag_w   = 24;
	localparam int word_w  = 2;
	localparam int byte_w  = 2;

	//////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////

	// Field view of a byte address from the top bit down
	typedef struct packed {
		logic [tag_w-1:0]   tag;
		logic [index_w-1:0] index;
		logic [word_w-1:0]  word;
		logic [byte_w-1:0]  byte_off;
	} cache_addr_t;

	// Same 32 bits seen as a raw bus address or as cache fields
	typedef union packed {
		logic [31:0] raw;
		cache_addr_t f;
	} cache_addr_u;

	// One line of four words with word 0 in the low bits
	typedef logic [line_words-1:0][31:0] line_t;

	//////////////////////////////////////////////////
	// Wishbone classic
	//////////////////////////////////////////////////

	// Master to slave
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  sel;
		logic [31:0] adr;
		logic [31:0] dat;
	} wb_req_t;

	// Slave to master
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

endpackage
